/* files.f */
+incdir+include
rtl/cpu_host_pkg.sv
rtl/word_counter.sv
rtl/instr_mem.sv
rtl/data_mem.sv
rtl/hex_display.sv
rtl/loader_fsm.sv
rtl/cpu_host_top.sv
tb/cpu_host_chk.sv
tb/cpu_host_tb.sv

/* Bender.yml */
package:
  name: cpu_host

sources:
  - include_dirs:
      - include
    files:
      - rtl/cpu_host_pkg.sv
      - rtl/word_counter.sv
      - rtl/instr_mem.sv
      - rtl/data_mem.sv
      - rtl/hex_display.sv
      - rtl/loader_fsm.sv
      - rtl/cpu_host_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/cpu_host_chk.sv
      - tb/cpu_host_tb.sv

/* tb/cpu_host_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_host_config.svh"

module cpu_host_tb import cpu_host_pkg::*; ();

	localparam logic [31:0] SEED = 32'hc8d8_e665;
	localparam int PROG_A = 20;
	localparam int PROG_B = 7;

	// Phase lengths with FIFO gaps for both programs
	localparam int LOAD_LEN   = (PROG_A + PROG_B + 2) * 8;
	localparam int RUN_LEN    = PROG_A + PROG_B + 2 * `DMEM_DEPTH + 8;
	localparam int UNLOAD_LEN = 2 * 2 * `DMEM_DEPTH * 4;
	localparam int MAX_CYCLES = 4 * (LOAD_LEN + RUN_LEN + UNLOAD_LEN) + 32;

	// Lit segments gfedcba for digits 0 to F
	localparam logic [6:0] LIT [16] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
		7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
	};

	logic                CLOCK_50;
	logic                rst;
	rx_fifo_t            rx;
	logic                rx_read;
	logic                tx_full;
	tx_fifo_t            tx;
	cpu_ctrl_t           cpu_ctrl;
	logic [IADDR_W:0]    cpu_pc;
	logic [IADDR_W-1:0]  imem_addr;
	logic [`IWORD_W-1:0] imem_data;
	dmem_wr_t            dmem_wr;
	hex_seg_t            hex;

	int seed = SEED;
	int errors = 0;
	int err_mark = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles;

	// Host side queues and the read in flight
	logic [`IWORD_W-1:0] host_q [$];
	logic [`IWORD_W-1:0] sink_q [$];
	logic [`IWORD_W-1:0] rd_word = '0;
	int                  rd_pend = 0;

	cpu_host_top i_dut (.*);

	initial begin
		CLOCK_50 = 1'b0;
		forever #10 CLOCK_50 = ~CLOCK_50;
	end

	// Hang guard
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge CLOCK_50);
			cycles++;
		end
		$display("Timeout: run not finished after %0d clock cycles", cycles);
		$display("Testbench failed");
		$finish;
	end

	// ==========================================================================
	// Helpers
	// ==========================================================================

	// Expected display for a word count
	function automatic hex_seg_t hex_expect(input int n);
		hex_seg_t h;
		for (int d = 0; d < 4; d++) begin
			h[d] = ~LIT[(n >> (4 * d)) & 15];
		end
		return h;
	endfunction

	// CPU result for one data index
	function automatic logic [`DWORD_W-1:0] data_pattern(input int prog, input int i);
		logic [31:0] idx;
		idx = 32'(i);
		return {SEED ^ (idx * 32'h0101_0101), ~SEED + idx + (32'(prog) << 24)};
	endfunction

	// Inputs change 2 ns after the edge and outputs are read there too
	task automatic next_cycle();
		@(posedge CLOCK_50);
		#2;
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input logic ok, input string what);
		assert (ok) else begin
			$display("Error at %0d ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		int total;
		total = errors + i_dut.i_chk.fail_count;
		tests_run++;
		if (total == err_mark) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", name, total - err_mark);
		end
		err_mark = total;
	endtask

	// ==========================================================================
	// Host FIFO and sink FIFO models
	// ==========================================================================

	// Word appears RX_LATENCY cycles after its read pulse
	always begin
		next_cycle();
		rx.data = $random(seed);
		if (rd_pend > 0) begin
			rd_pend--;
			if (rd_pend == 0) begin
				rx.data = rd_word;
			end
		end
		if (rx_read) begin
			check_true(host_q.size() > 0, "rx_read pulse with the host FIFO empty");
			if (host_q.size() > 0) begin
				rd_word = host_q.pop_front();
			end
			rd_pend = `RX_LATENCY;
		end
		// Random gaps on top of a real empty queue
		rx.empty = (host_q.size() == 0) || (($random(seed) & 3) == 0);
	end

	always begin
		next_cycle();
		if (tx.write) begin
			sink_q.push_back(tx.data);
		end
		tx_full = (($random(seed) & 3) == 0);
	end

	// ==========================================================================
	// One program: load, CPU model run, unload
	// ==========================================================================

	task automatic run_program(input int prog, input int n_words);
		logic [`IWORD_W-1:0] words [$];
		logic [`IWORD_W-1:0] w;
		logic [`DWORD_W-1:0] d;
		int                  fall;
		int                  shown;
		sink_q.delete();
		for (int i = 0; i < n_words; i++) begin
			w = $random(seed);
			// Keep the body free of terminators
			if (w == `TERMINATOR) begin
				w = '0;
			end
			words.push_back(w);
			host_q.push_back(w);
		end
		host_q.push_back(`TERMINATOR);

		// Display counts up from zero by one word at a time
		shown = 0;
		while (!cpu_ctrl.run) begin
			if (hex === hex_expect(shown + 1)) begin
				shown++;
			end
			check_value("hex", hex, hex_expect(shown));
			next_cycle();
		end

		// First run cycle carries the CPU reset
		check_value("cpu_ctrl.rst", cpu_ctrl.rst, 1'b1);
		check_value("hex", hex, hex_expect(n_words));

		// Fetch back every loaded word
		for (int i = 0; i < n_words; i++) begin
			imem_addr = IADDR_W'(i);
			next_cycle();
			check_value("cpu_ctrl.run", cpu_ctrl.run, 1'b1);
			check_value("cpu_ctrl.rst", cpu_ctrl.rst, 1'b0);
			check_value("imem_data", imem_data, words[i]);
		end

		// Store results, one index per cycle
		for (int i = 0; i < `DMEM_DEPTH; i++) begin
			dmem_wr.en   = 1'b1;
			dmem_wr.addr = DADDR_W'(i);
			dmem_wr.data = data_pattern(prog, i);
			next_cycle();
			check_value("cpu_ctrl.run", cpu_ctrl.run, 1'b1);
		end
		dmem_wr.en = 1'b0;

		// PC off the end stops the run
		cpu_pc = (IADDR_W + 1)'(`IMEM_DEPTH);
		fall = 0;
		while (cpu_ctrl.run && fall < 4) begin
			next_cycle();
			fall++;
		end
		check_true(!cpu_ctrl.run && fall <= 2, "run still high two cycles after the end PC");
		cpu_pc = '0;

		// Stray store with run low must not reach data memory
		dmem_wr.en   = 1'b1;
		dmem_wr.addr = DADDR_W'(`DMEM_DEPTH - 1);
		dmem_wr.data = ~data_pattern(prog, `DMEM_DEPTH - 1);
		next_cycle();
		dmem_wr.en = 1'b0;

		// Unload and a quiet tail to catch extra writes
		while (sink_q.size() < 2 * `DMEM_DEPTH) next_cycle();
		repeat (6) next_cycle();
		check_value("tx.write count", sink_q.size(), 2 * `DMEM_DEPTH);
		for (int i = 0; i < `DMEM_DEPTH; i++) begin
			d = data_pattern(prog, i);
			check_value("tx.data upper", sink_q[2 * i], d[`DWORD_W-1 -: `IWORD_W]);
			check_value("tx.data lower", sink_q[2 * i + 1], d[`IWORD_W-1:0]);
		end
		check_value("hex", hex, hex_expect(0));
	endtask

	initial begin
		rst       = 1'b1;
		rx.data   = '0;
		rx.empty  = 1'b1;
		tx_full   = 1'b0;
		cpu_pc    = '0;
		imem_addr = '0;
		dmem_wr   = '0;
		repeat (8) @(posedge CLOCK_50);
		#2;
		rst = 1'b0;

		// Nothing queued, nothing moves
		for (int i = 0; i < 10; i++) begin
			next_cycle();
			check_value("rx_read", rx_read, 1'b0);
			check_value("tx.write", tx.write, 1'b0);
			check_value("cpu_ctrl", cpu_ctrl, 2'b00);
		end
		end_test("reset_idle");

		run_program(1, PROG_A);
		end_test("program_a");

		// Second load restarts at index 0
		run_program(2, PROG_B);
		end_test("program_b");

		$display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, errors, i_dut.i_chk.fail_count);
		if (tests_failed == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/cpu_host_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_host_config.svh"

// Protocol rules on the loader top level
module cpu_host_chk import cpu_host_pkg::*; (
	input logic             CLOCK_50,
	input logic             rst,
	input rx_fifo_t         rx,
	input logic             rx_read,
	input logic             tx_full,
	input tx_fifo_t         tx,
	input cpu_ctrl_t        cpu_ctrl,
	input logic [IADDR_W:0] cpu_pc
);

	// Failed assertions, summed into the testbench result
	int unsigned fail_count = 0;

	// ==========================================================================
	// Reset and host FIFO reads
	// ==========================================================================

	a_reset_quiet: assert property (@(posedge CLOCK_50)
		rst |=> (!rx_read && !tx.write && !cpu_ctrl.run && !cpu_ctrl.rst))
		else begin $error("outputs active after reset"); fail_count++; end

	// Read only on a cycle that saw data waiting
	a_read_ready: assert property (@(posedge CLOCK_50) disable iff (rst)
		rx_read |-> !$past(rx.empty))
		else begin $error("rx_read while rx.empty was high"); fail_count++; end

	a_read_pulse: assert property (@(posedge CLOCK_50) disable iff (rst)
		rx_read |=> !rx_read)
		else begin $error("rx_read longer than one cycle"); fail_count++; end

	// ==========================================================================
	// CPU run window
	// ==========================================================================

	// Reset pulse only with run, and then a plain run cycle
	a_start_pulse: assert property (@(posedge CLOCK_50) disable iff (rst)
		cpu_ctrl.rst |-> cpu_ctrl.run ##1 (cpu_ctrl.run && !cpu_ctrl.rst))
		else begin $error("CPU reset pulse malformed"); fail_count++; end

	a_run_ends: assert property (@(posedge CLOCK_50) disable iff (rst)
		(cpu_ctrl.run && !cpu_ctrl.rst && cpu_pc == `IMEM_DEPTH) |-> ##[1:2] !cpu_ctrl.run)
		else begin $error("run held past the end PC"); fail_count++; end

	// No early stop
	a_run_holds: assert property (@(posedge CLOCK_50) disable iff (rst)
		$fell(cpu_ctrl.run) |-> $past(cpu_pc == `IMEM_DEPTH))
		else begin $error("run fell before the end PC"); fail_count++; end

	// ==========================================================================
	// Host FIFO writes
	// ==========================================================================

	a_tx_room: assert property (@(posedge CLOCK_50) disable iff (rst)
		tx.write |-> !$past(tx_full))
		else begin $error("tx.write after tx_full was high"); fail_count++; end

	a_tx_gap: assert property (@(posedge CLOCK_50) disable iff (rst)
		tx.write |=> !tx.write)
		else begin $error("tx.write on adjacent cycles"); fail_count++; end

endmodule

bind cpu_host_top cpu_host_chk i_chk (.*);

`default_nettype wire

/* rtl/cpu_host_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_host_config.svh"

// Host loader around an external CPU core
module cpu_host_top import cpu_host_pkg::*; (
	input  logic                CLOCK_50,
	input  logic                rst,
	input  rx_fifo_t            rx,
	output logic                rx_read,
	input  logic                tx_full,
	output tx_fifo_t            tx,
	output cpu_ctrl_t           cpu_ctrl,
	input  logic [IADDR_W:0]    cpu_pc,
	input  logic [IADDR_W-1:0]  imem_addr,
	output logic [`IWORD_W-1:0] imem_data,
	input  dmem_wr_t            dmem_wr,
	output hex_seg_t            hex
);

	// Counter handshakes
	logic               load_last;
	logic               load_inc;
	logic               data_last;
	logic               data_inc;
	logic               cnt_clear;
	logic [IADDR_W-1:0] load_count;
	logic [DADDR_W-1:0] data_count;

	// Memory paths
	logic                imem_we;
	logic [`IWORD_W-1:0] imem_wdata;
	logic [`DWORD_W-1:0] dmem_rdata;
	dmem_wr_t            dmem_wr_run;

	// ==========================================================================
	// Sequencer and index counters
	// ==========================================================================

	loader_fsm i_fsm (
		.CLOCK_50   (CLOCK_50),
		.rst        (rst),
		.rx         (rx),
		.rx_read    (rx_read),
		.tx_full    (tx_full),
		.tx         (tx),
		.cpu_pc     (cpu_pc),
		.cpu_ctrl   (cpu_ctrl),
		.load_last  (load_last),
		.load_inc   (load_inc),
		.data_last  (data_last),
		.data_inc   (data_inc),
		.cnt_clear  (cnt_clear),
		.imem_we    (imem_we),
		.imem_wdata (imem_wdata),
		.dmem_rdata (dmem_rdata)
	);

	// Load index, also the word count on the display
	word_counter #(.DEPTH(`IMEM_DEPTH)) i_load_cnt (
		.CLOCK_50 (CLOCK_50),
		.rst      (rst),
		.clear    (cnt_clear),
		.inc      (load_inc),
		.count    (load_count),
		.last     (load_last)
	);

	// Unload index
	word_counter #(.DEPTH(`DMEM_DEPTH)) i_data_cnt (
		.CLOCK_50 (CLOCK_50),
		.rst      (rst),
		.clear    (cnt_clear),
		.inc      (data_inc),
		.count    (data_count),
		.last     (data_last)
	);

	// ==========================================================================
	// Memories and display
	// ==========================================================================

	instr_mem i_imem (
		.CLOCK_50 (CLOCK_50),
		.we       (imem_we),
		.waddr    (load_count),
		.wdata    (imem_wdata),
		.raddr    (imem_addr),
		.rdata    (imem_data)
	);

	// CPU stores only count while it runs
	always_comb begin
		dmem_wr_run    = dmem_wr;
		dmem_wr_run.en = dmem_wr.en && cpu_ctrl.run;
	end

	data_mem i_dmem (
		.CLOCK_50 (CLOCK_50),
		.wr       (dmem_wr_run),
		.raddr    (data_count),
		.rdata    (dmem_rdata)
	);

	hex_display i_hex (
		.value (16'(load_count)),
		.hex   (hex)
	);

endmodule

`default_nettype wire

/* rtl/loader_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_host_config.svh"

// Sequencer for program load, CPU run and result unload
module loader_fsm import cpu_host_pkg::*; (
	input  logic                CLOCK_50,
	input  logic                rst,
	input  rx_fifo_t            rx,
	output logic                rx_read,
	input  logic                tx_full,
	output tx_fifo_t            tx,
	input  logic [IADDR_W:0]    cpu_pc,
	output cpu_ctrl_t           cpu_ctrl,
	input  logic                load_last,
	output logic                load_inc,
	input  logic                data_last,
	output logic                data_inc,
	output logic                cnt_clear,
	output logic                imem_we,
	output logic [`IWORD_W-1:0] imem_wdata,
	input  logic [`DWORD_W-1:0] dmem_rdata
);

	localparam int LAT_W = $clog2(`RX_LATENCY + 1);

	loader_state_e state;

	// Cycles spent waiting on FIFO read data
	logic [LAT_W-1:0] lat_cnt;

	logic is_term;
	logic pc_done;
	logic lo_fire;

	// ==========================================================================
	// Decode of the current cycle
	// ==========================================================================

	// All ones closes the program
	assign is_term = (rx.data == `TERMINATOR);

	// CPU walked off the end of instruction memory
	assign pc_done = (cpu_pc == (IADDR_W + 1)'(`IMEM_DEPTH));

	// Low half goes out once the FIFO has room, never right after a write
	assign lo_fire = (state == SEND_LOW) && !tx_full && !tx.write;

	// Word lands at the load index on this edge
	assign imem_we    = (state == CAPTURE) && !is_term;
	assign imem_wdata = rx.data;

	// Hold the index on the top slot, load stops there anyway
	assign load_inc = imem_we && !load_last;

	// Next data index, or restart both counters after the last one
	assign data_inc  = lo_fire && !data_last;
	assign cnt_clear = lo_fire && data_last;

	// CPU reset pulse rides on the first run cycle
	always_comb begin
		cpu_ctrl.run = (state == START_CPU) || (state == RUN_CPU);
		cpu_ctrl.rst = (state == START_CPU);
	end

	// ==========================================================================
	// State and registered FIFO strobes
	// ==========================================================================

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state    <= WAIT_WORD;
			rx_read  <= 1'b0;
			tx.write <= 1'b0;
			lat_cnt  <= '0;
		end else begin
			// Strobes last one cycle
			rx_read  <= 1'b0;
			tx.write <= 1'b0;

			case (state)
				// Pull a word when the host has one
				WAIT_WORD: begin
					if (!rx.empty) begin
						rx_read <= 1'b1;
						lat_cnt <= '0;
						state   <= READ_WAIT;
					end
				end

				// FIFO read latency
				READ_WAIT: begin
					if (lat_cnt == LAT_W'(`RX_LATENCY - 1)) begin
						state <= CAPTURE;
					end else begin
						lat_cnt <= lat_cnt + 1'b1;
					end
				end

				// Terminator or a full memory starts the CPU
				CAPTURE: begin
					if (is_term || load_last) begin
						state <= START_CPU;
					end else begin
						state <= WAIT_WORD;
					end
				end

				// Single cycle of run with reset
				START_CPU: begin
					state <= RUN_CPU;
				end

				RUN_CPU: begin
					if (pc_done) begin
						state <= FETCH;
					end
				end

				// Data index on the memory, read lands next cycle
				FETCH: begin
					state <= SEND_HIGH;
				end

				// Upper half first
				SEND_HIGH: begin
					if (!tx_full) begin
						tx.write <= 1'b1;
						tx.data  <= dmem_rdata[`DWORD_W-1 -: `IWORD_W];
						state    <= SEND_LOW;
					end
				end

				SEND_LOW: begin
					if (lo_fire) begin
						tx.write <= 1'b1;
						tx.data  <= dmem_rdata[`IWORD_W-1:0];
						// Back to loading after the last word
						state    <= data_last ? WAIT_WORD : FETCH;
					end
				end

				default: begin
					state <= WAIT_WORD;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/hex_display.sv */
`timescale 1ns/1ps
`default_nettype none

// Four hex digits onto active-low seven-segment outputs
module hex_display import cpu_host_pkg::*; (
	input  logic [15:0] value,
	output hex_seg_t    hex
);

	// Nibble to segments, a in bit 0, lit when low
	function automatic logic [6:0] seg_of(input logic [3:0] nib);
		case (nib)
			4'h0: seg_of = 7'b1000000;
			4'h1: seg_of = 7'b1111001;
			4'h2: seg_of = 7'b0100100;
			4'h3: seg_of = 7'b0110000;
			4'h4: seg_of = 7'b0011001;
			4'h5: seg_of = 7'b0010010;
			4'h6: seg_of = 7'b0000010;
			4'h7: seg_of = 7'b1111000;
			4'h8: seg_of = 7'b0000000;
			4'h9: seg_of = 7'b0010000;
			4'ha: seg_of = 7'b0001000;
			4'hb: seg_of = 7'b0000011;
			4'hc: seg_of = 7'b1000110;
			4'hd: seg_of = 7'b0100001;
			4'he: seg_of = 7'b0000110;
			default: seg_of = 7'b0001110;
		endcase
	endfunction

	// One digit per nibble, least significant on digit 0
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			hex[i] = seg_of(value[4*i +: 4]);
		end
	end

endmodule

`default_nettype wire

/* rtl/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_host_config.svh"

// Result store, written by the CPU and drained by the unloader
module data_mem import cpu_host_pkg::*; (
	input  logic                CLOCK_50,
	input  dmem_wr_t            wr,
	input  logic [DADDR_W-1:0]  raddr,
	output logic [`DWORD_W-1:0] rdata
);

	logic [`DWORD_W-1:0] mem [`DMEM_DEPTH];

	// CPU store port
	always_ff @(posedge CLOCK_50) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// Unloader read, one cycle behind the address
	always_ff @(posedge CLOCK_50) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

/* rtl/instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_host_config.svh"

// Program store, filled by the loader and fetched by the CPU
module instr_mem import cpu_host_pkg::*; (
	input  logic                CLOCK_50,
	input  logic                we,
	input  logic [IADDR_W-1:0]  waddr,
	input  logic [`IWORD_W-1:0] wdata,
	input  logic [IADDR_W-1:0]  raddr,
	output logic [`IWORD_W-1:0] rdata
);

	logic [`IWORD_W-1:0] mem [`IMEM_DEPTH];

	// Loader write port
	always_ff @(posedge CLOCK_50) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// CPU fetch, same cycle
	assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* rtl/word_counter.sv */
`timescale 1ns/1ps
`default_nettype none

// Index counter shared by the load and unload paths
module word_counter #(
	parameter int DEPTH = 64
) (
	input  logic                     CLOCK_50,
	input  logic                     rst,
	input  logic                     clear,
	input  logic                     inc,
	output logic [$clog2(DEPTH)-1:0] count,
	output logic                     last
);

	localparam int W = $clog2(DEPTH);

	// Clear wins over increment
	always_ff @(posedge CLOCK_50) begin
		if (rst || clear) begin
			count <= '0;
		end else if (inc) begin
			count <= count + 1'b1;
		end
	end

	// Top index of the memory
	assign last = (count == W'(DEPTH - 1));

endmodule

`default_nettype wire

/* rtl/cpu_host_pkg.sv */
`default_nettype none

`include "cpu_host_config.svh"

package cpu_host_pkg;

	// Index widths for both memories
	localparam int IADDR_W = $clog2(`IMEM_DEPTH);
	localparam int DADDR_W = $clog2(`DMEM_DEPTH);

	// Load, run, unload sequence
	typedef enum logic [2:0] {
		WAIT_WORD,
		READ_WAIT,
		CAPTURE,
		START_CPU,
		RUN_CPU,
		FETCH,
		SEND_HIGH,
		SEND_LOW
	} loader_state_e;

	// Host to FPGA FIFO read side
	typedef struct packed {
		logic [`IWORD_W-1:0] data;
		logic                empty;
	} rx_fifo_t;

	// FPGA to host FIFO write side
	typedef struct packed {
		logic [`IWORD_W-1:0] data;
		logic                write;
	} tx_fifo_t;

	// Levels to the external CPU core
	typedef struct packed {
		logic run;
		logic rst;
	} cpu_ctrl_t;

	// CPU store port into data memory
	typedef struct packed {
		logic                en;
		logic [DADDR_W-1:0]  addr;
		logic [`DWORD_W-1:0] data;
	} dmem_wr_t;

	// Digit 0 in the low field, active-low segments
	typedef logic [3:0][6:0] hex_seg_t;

endpackage

`default_nettype wire

/* include/cpu_host_config.svh */
`ifndef CPU_HOST_CONFIG_SVH
`define CPU_HOST_CONFIG_SVH

// ==========================================================================
// Loader sizing
// ==========================================================================

// Instruction words, also the PC value that ends a run
`define IMEM_DEPTH 64

// Data words streamed back to the host
`define DMEM_DEPTH 64

// FIFO and instruction word width
`define IWORD_W 32

// Data memory word, sent as two FIFO words
`define DWORD_W 64

// All-ones word closes a program load
`define TERMINATOR {`IWORD_W{1'b1}}

// Read pulse to valid FIFO data, in cycles
`define RX_LATENCY 2

`endif
